// File: verilog/cpu_pkg.sv
// Shared encodings and stage register types of the MIPS pipeline, imported by every stage.
`default_nettype none

package cpu_pkg;

	// ----------------------------------------------------------------------
	// Instruction encodings.
	// ----------------------------------------------------------------------
	localparam logic [5:0] op_rtype = 6'h00;
	localparam logic [5:0] op_j     = 6'h02;
	localparam logic [5:0] op_jal   = 6'h03;
	localparam logic [5:0] op_beq   = 6'h04;
	localparam logic [5:0] op_bne   = 6'h05;
	localparam logic [5:0] op_addiu = 6'h09;
	localparam logic [5:0] op_andi  = 6'h0c;
	localparam logic [5:0] op_ori   = 6'h0d;
	localparam logic [5:0] op_lui   = 6'h0f;
	localparam logic [5:0] op_lw    = 6'h23;
	localparam logic [5:0] op_sw    = 6'h2b;

	// Function field of R-type instructions.
	localparam logic [5:0] fn_sll  = 6'h00;
	localparam logic [5:0] fn_srl  = 6'h02;
	localparam logic [5:0] fn_jr   = 6'h08;
	localparam logic [5:0] fn_jalr = 6'h09;
	localparam logic [5:0] fn_addu = 6'h21;
	localparam logic [5:0] fn_subu = 6'h23;
	localparam logic [5:0] fn_and  = 6'h24;
	localparam logic [5:0] fn_or   = 6'h25;
	localparam logic [5:0] fn_xor  = 6'h26;
	localparam logic [5:0] fn_slt  = 6'h2a;

	// Writeback source select.
	localparam logic [1:0] wb_alu  = 2'd0;
	localparam logic [1:0] wb_load = 2'd1;
	localparam logic [1:0] wb_link = 2'd2;

	typedef enum logic [3:0] {
		alu_add, alu_sub, alu_and, alu_or, alu_xor,
		alu_slt, alu_sll, alu_srl, alu_lui
	} alu_op_e;

	// ----------------------------------------------------------------------
	// Stage registers and side channels.
	// ----------------------------------------------------------------------
	typedef struct packed {
		logic        valid;
		logic [31:0] pc;
		logic [31:0] inst;
	} if_id_t;

	typedef struct packed {
		logic        valid;
		logic [31:0] pc;
		logic [31:0] rfa;
		logic [31:0] rfb;
		logic [31:0] imm;
		logic [4:0]  shamt;
		logic [4:0]  rf_waddr;
		logic        rfw;
		logic [1:0]  wbsource;
		logic        drw;
		alu_op_e     alu_op;
		logic        b_sel;
		logic        br;
		logic        br_ne;
		logic        j;
		logic        jr;
		logic [25:0] jaddr;
	} id_ex_t;

	typedef struct packed {
		logic        valid;
		logic        rfw;
		logic [4:0]  rf_waddr;
		logic [1:0]  wbsource;
		logic        drw;
		logic [31:0] alu_result;
		logic [31:0] sdata;
		logic [31:0] link;
	} ex_mem_t;

	// Register file write port, also the retire output.
	typedef struct packed {
		logic        rfw;
		logic [4:0]  waddr;
		logic [31:0] wdata;
	} wb_t;

	typedef struct packed {
		logic [31:0] addr;
		logic [31:0] data;
	} st_t;

	typedef struct packed {
		logic        taken;
		logic [31:0] target;
	} redirect_t;

endpackage

`default_nettype wire

// File: verilog/cpu_if.sv
// Fetch stage: program counter, loadable instruction memory and the fetch/decode register.
`default_nettype none
`timescale 1ns/100ps

module cpu_if #(
	parameter int IMEM_WORDS = 256
) (
	input  wire logic              clk,
	input  wire logic              rst,
	input  wire logic              prog_we,
	input  wire logic [31:0]       prog_addr,
	input  wire logic [31:0]       prog_data,
	input  wire cpu_pkg::redirect_t redirect,
	output cpu_pkg::if_id_t         if_id
);

	localparam int iaw = $clog2(IMEM_WORDS);

	logic [31:0] imem [IMEM_WORDS];
	logic [31:0] pc;
	logic [31:0] inst_rd;

	// ----------------------------------------------------------------------
	// Instruction memory.
	// ----------------------------------------------------------------------
	// The load port takes a byte address, one word per cycle.
	always_ff @(posedge clk) begin
		if (prog_we)
			imem[prog_addr[iaw+1:2]] <= prog_data;
	end

	assign inst_rd = imem[pc[iaw+1:2]];

	// ----------------------------------------------------------------------
	// PC and fetch/decode register.
	// ----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= 32'd0;
			if_id.valid <= 1'b0;
		end else if (redirect.taken) begin
			// The word fetched now is on the wrong path.
			pc <= redirect.target;
			if_id.valid <= 1'b0;
		end else begin
			pc <= pc + 32'd4;
			if_id.valid <= 1'b1;
		end
		if_id.pc <= pc;
		if_id.inst <= inst_rd;
	end

	// Branch and jump targets must land on a word.
	a_target_aligned: assert property (
		@(posedge clk) disable iff (rst)
		redirect.taken |-> (redirect.target[1:0] == 2'b00)
	);

endmodule

`default_nettype wire

// File: verilog/cpu_id.sv
// Decode stage: register file, control decode and the decode/execute register.
`default_nettype none
`timescale 1ns/100ps

module cpu_id (
	input  wire logic               clk,
	input  wire logic               rst,
	input  wire cpu_pkg::if_id_t    if_id,
	input  wire cpu_pkg::wb_t       wb,
	input  wire cpu_pkg::redirect_t redirect,
	output cpu_pkg::id_ex_t          id_ex
);

	import cpu_pkg::*;

	logic [31:0] rf [31:1];

	logic [5:0]  opcode;
	logic [5:0]  funct;
	logic [4:0]  rs;
	logic [4:0]  rt;
	logic [4:0]  rd;
	logic [15:0] imm16;
	logic [31:0] rfa;
	logic [31:0] rfb;

	logic        c_rfw;
	logic [1:0]  c_wbsource;
	logic        c_drw;
	alu_op_e     c_alu;
	logic        c_zext;
	logic        c_bsel;
	logic        c_dst_rd;
	logic        c_dst_31;
	logic        c_br;
	logic        c_br_ne;
	logic        c_j;
	logic        c_jr;

	id_ex_t      dec;

	// Instruction fields.
	assign opcode = if_id.inst[31:26];
	assign rs     = if_id.inst[25:21];
	assign rt     = if_id.inst[20:16];
	assign rd     = if_id.inst[15:11];
	assign imm16  = if_id.inst[15:0];
	assign funct  = if_id.inst[5:0];

	// ----------------------------------------------------------------------
	// Register file, written on the falling edge by writeback.
	// ----------------------------------------------------------------------
	always_ff @(negedge clk) begin
		if (wb.rfw && wb.waddr != 5'd0)
			rf[wb.waddr] <= wb.wdata;
	end

	assign rfa = (rs == 5'd0) ? 32'd0 : rf[rs];
	assign rfb = (rt == 5'd0) ? 32'd0 : rf[rt];

	// ----------------------------------------------------------------------
	// Control decode. Anything not listed decodes as a nop.
	// ----------------------------------------------------------------------
	always_comb begin
		c_rfw = 1'b0;
		c_wbsource = wb_alu;
		c_drw = 1'b0;
		c_alu = alu_add;
		c_zext = 1'b0;
		c_bsel = 1'b0;
		c_dst_rd = 1'b0;
		c_dst_31 = 1'b0;
		c_br = 1'b0;
		c_br_ne = 1'b0;
		c_j = 1'b0;
		c_jr = 1'b0;
		case (opcode)
			op_rtype: begin
				c_dst_rd = 1'b1;
				case (funct)
					fn_addu: begin c_rfw = 1'b1; c_alu = alu_add; end
					fn_subu: begin c_rfw = 1'b1; c_alu = alu_sub; end
					fn_and:  begin c_rfw = 1'b1; c_alu = alu_and; end
					fn_or:   begin c_rfw = 1'b1; c_alu = alu_or;  end
					fn_xor:  begin c_rfw = 1'b1; c_alu = alu_xor; end
					fn_slt:  begin c_rfw = 1'b1; c_alu = alu_slt; end
					fn_sll:  begin c_rfw = 1'b1; c_alu = alu_sll; end
					fn_srl:  begin c_rfw = 1'b1; c_alu = alu_srl; end
					// Jr only redirects.
					fn_jr:   c_jr = 1'b1;
					fn_jalr: begin c_jr = 1'b1; c_rfw = 1'b1; c_wbsource = wb_link; end
					default: ;
				endcase
			end
			op_addiu: begin c_rfw = 1'b1; c_bsel = 1'b1; end
			op_andi:  begin c_rfw = 1'b1; c_bsel = 1'b1; c_zext = 1'b1; c_alu = alu_and; end
			op_ori:   begin c_rfw = 1'b1; c_bsel = 1'b1; c_zext = 1'b1; c_alu = alu_or; end
			op_lui:   begin c_rfw = 1'b1; c_bsel = 1'b1; c_alu = alu_lui; end
			op_lw:    begin c_rfw = 1'b1; c_bsel = 1'b1; c_wbsource = wb_load; end
			op_sw:    begin c_drw = 1'b1; c_bsel = 1'b1; end
			op_beq:   c_br = 1'b1;
			op_bne:   begin c_br = 1'b1; c_br_ne = 1'b1; end
			op_j:     c_j = 1'b1;
			op_jal:   begin c_j = 1'b1; c_rfw = 1'b1; c_wbsource = wb_link; c_dst_31 = 1'b1; end
			default: ;
		endcase
	end

	always_comb begin
		dec.valid    = if_id.valid;
		dec.pc       = if_id.pc;
		dec.rfa      = rfa;
		dec.rfb      = rfb;
		dec.imm      = c_zext ? {16'h0000, imm16} : {{16{imm16[15]}}, imm16};
		dec.shamt    = if_id.inst[10:6];
		dec.rf_waddr = c_dst_31 ? 5'd31 : (c_dst_rd ? rd : rt);
		dec.rfw      = c_rfw & if_id.valid;
		dec.wbsource = c_wbsource;
		dec.drw      = c_drw & if_id.valid;
		dec.alu_op   = c_alu;
		dec.b_sel    = c_bsel;
		dec.br       = c_br;
		dec.br_ne    = c_br_ne;
		dec.j        = c_j;
		dec.jr       = c_jr;
		dec.jaddr    = if_id.inst[25:0];
	end

	// Decode/execute register. A taken redirect squashes the younger instruction.
	always_ff @(posedge clk) begin
		id_ex <= dec;
		if (rst || redirect.taken) begin
			id_ex.valid <= 1'b0;
			id_ex.rfw <= 1'b0;
			id_ex.drw <= 1'b0;
		end
	end

	a_rfw_needs_valid: assert property (
		@(posedge clk) disable iff (rst)
		!id_ex.valid |-> !id_ex.rfw
	);

endmodule

`default_nettype wire

// File: verilog/cpu_ex.sv
// Execute stage: ALU, branch and jump resolution, redirect and the execute/memory register.
`default_nettype none
`timescale 1ns/100ps

module cpu_ex (
	input  wire logic            clk,
	input  wire logic            rst,
	input  wire cpu_pkg::id_ex_t id_ex,
	output cpu_pkg::ex_mem_t      ex_mem,
	output cpu_pkg::redirect_t    redirect
);

	import cpu_pkg::*;

	logic [31:0] op_b;
	logic [31:0] alu_y;
	logic [31:0] pc4;
	logic [31:0] br_target;
	logic [31:0] j_target;
	logic        eq;
	logic        br_taken;

	// ----------------------------------------------------------------------
	// ALU.
	// ----------------------------------------------------------------------
	assign op_b = id_ex.b_sel ? id_ex.imm : id_ex.rfb;

	always_comb begin
		case (id_ex.alu_op)
			alu_add: alu_y = id_ex.rfa + op_b;
			alu_sub: alu_y = id_ex.rfa - op_b;
			alu_and: alu_y = id_ex.rfa & op_b;
			alu_or:  alu_y = id_ex.rfa | op_b;
			alu_xor: alu_y = id_ex.rfa ^ op_b;
			alu_slt: alu_y = {31'd0, $signed(id_ex.rfa) < $signed(op_b)};
			// Shifts take rt as the source and shamt as the distance.
			alu_sll: alu_y = op_b << id_ex.shamt;
			alu_srl: alu_y = op_b >> id_ex.shamt;
			alu_lui: alu_y = {op_b[15:0], 16'h0000};
			default: alu_y = 32'd0;
		endcase
	end

	// ----------------------------------------------------------------------
	// Flow change.
	// ----------------------------------------------------------------------
	assign pc4       = id_ex.pc + 32'd4;
	assign br_target = pc4 + {id_ex.imm[29:0], 2'b00};
	assign j_target  = {pc4[31:28], id_ex.jaddr, 2'b00};
	assign eq        = (id_ex.rfa == id_ex.rfb);
	assign br_taken  = id_ex.br & (eq ^ id_ex.br_ne);

	always_comb begin
		redirect.taken = id_ex.valid & (br_taken | id_ex.j | id_ex.jr);
		if (id_ex.jr)
			redirect.target = id_ex.rfa;
		else if (id_ex.j)
			redirect.target = j_target;
		else
			redirect.target = br_target;
	end

	// Execute/memory register.
	always_ff @(posedge clk) begin
		if (rst) begin
			ex_mem.valid <= 1'b0;
			ex_mem.rfw <= 1'b0;
			ex_mem.drw <= 1'b0;
		end else begin
			ex_mem.valid <= id_ex.valid;
			ex_mem.rfw <= id_ex.rfw & id_ex.valid;
			ex_mem.drw <= id_ex.drw & id_ex.valid;
		end
		ex_mem.rf_waddr <= id_ex.rf_waddr;
		ex_mem.wbsource <= id_ex.wbsource;
		ex_mem.alu_result <= alu_y;
		ex_mem.sdata <= id_ex.rfb;
		ex_mem.link <= pc4;
	end

	// The instruction behind a taken redirect must be squashed.
	a_redirect_squashes: assert property (
		@(posedge clk) disable iff (rst)
		redirect.taken |=> !id_ex.valid
	);

endmodule

`default_nettype wire

// File: verilog/cpu_mem.sv
// Memory stage: data memory, store strobe, writeback select and the memory/writeback register.
`default_nettype none
`timescale 1ns/100ps

module cpu_mem #(
	parameter int DMEM_WORDS = 64
) (
	input  wire logic             clk,
	input  wire logic             rst,
	input  wire cpu_pkg::ex_mem_t ex_mem,
	output cpu_pkg::wb_t           wb,
	output logic                   st_valid,
	output cpu_pkg::st_t           st
);

	import cpu_pkg::*;

	localparam int daw = $clog2(DMEM_WORDS);

	logic [31:0] dmem [DMEM_WORDS];
	logic [31:0] ld_data;
	logic [31:0] wdata;

	// Word access only, indexed above the byte offset.
	always_ff @(posedge clk) begin
		if (ex_mem.drw)
			dmem[ex_mem.alu_result[daw+1:2]] <= ex_mem.sdata;
	end

	assign ld_data = dmem[ex_mem.alu_result[daw+1:2]];

	always_comb begin
		case (ex_mem.wbsource)
			wb_load: wdata = ld_data;
			wb_link: wdata = ex_mem.link;
			default: wdata = ex_mem.alu_result;
		endcase
	end

	// ----------------------------------------------------------------------
	// Memory/writeback register and store report.
	// ----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			wb.rfw <= 1'b0;
			st_valid <= 1'b0;
		end else begin
			wb.rfw <= ex_mem.rfw;
			st_valid <= ex_mem.drw;
		end
		wb.waddr <= ex_mem.rf_waddr;
		wb.wdata <= wdata;
		st.addr <= ex_mem.alu_result;
		st.data <= ex_mem.sdata;
	end

	a_store_in_range: assert property (
		@(posedge clk) disable iff (rst)
		ex_mem.drw |-> (ex_mem.alu_result < 32'(DMEM_WORDS * 4))
	);

endmodule

`default_nettype wire

// File: verilog/cpu_top.sv
// Pipeline top level: connects fetch, decode, execute and memory; the testbench drives it.
`default_nettype none
`timescale 1ns/100ps

module cpu_top #(
	parameter int IMEM_WORDS = 256,
	parameter int DMEM_WORDS = 64
) (
	input  wire logic        clk,
	input  wire logic        rst,
	input  wire logic        prog_we,
	input  wire logic [31:0] prog_addr,
	input  wire logic [31:0] prog_data,
	output cpu_pkg::wb_t      wb,
	output logic              st_valid,
	output cpu_pkg::st_t      st
);

	import cpu_pkg::*;

	if_id_t    if_id;
	id_ex_t    id_ex;
	ex_mem_t   ex_mem;
	redirect_t redirect;

	cpu_if #(
		.IMEM_WORDS(IMEM_WORDS)
	) if0 (
		.clk      (clk),
		.rst      (rst),
		.prog_we  (prog_we),
		.prog_addr(prog_addr),
		.prog_data(prog_data),
		.redirect (redirect),
		.if_id    (if_id)
	);

	// Decode also takes the writeback port for its register file.
	cpu_id id0 (
		.clk     (clk),
		.rst     (rst),
		.if_id   (if_id),
		.wb      (wb),
		.redirect(redirect),
		.id_ex   (id_ex)
	);

	cpu_ex ex0 (
		.clk     (clk),
		.rst     (rst),
		.id_ex   (id_ex),
		.ex_mem  (ex_mem),
		.redirect(redirect)
	);

	cpu_mem #(
		.DMEM_WORDS(DMEM_WORDS)
	) mem0 (
		.clk     (clk),
		.rst     (rst),
		.ex_mem  (ex_mem),
		.wb      (wb),
		.st_valid(st_valid),
		.st      (st)
	);

endmodule

`default_nettype wire

// File: sim/tb_clk.sv
// Testbench clock source; the testbench top instantiates it to drive clk.
`default_nettype none
`timescale 1ns/100ps

module tb_clk #(
	parameter int PERIOD_NS = 8
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2.0) clk = ~clk;
	end

endmodule

`default_nettype wire

// File: sim/tb_isa_model.svh
// Random program generator and sequential ISA model; included inside the testbench top module.
`ifndef TB_ISA_MODEL_SVH
`define TB_ISA_MODEL_SVH

// Result categories, one per reported test.
localparam int t_reset  = 0;
localparam int t_alu    = 1;
localparam int t_imm    = 2;
localparam int t_mem    = 3;
localparam int t_branch = 4;
localparam int t_jump   = 5;

localparam int n_groups = 120;
localparam int n_kinds  = 10;
localparam int iaw      = $clog2(IMEM_WORDS);
localparam int daw      = $clog2(DMEM_WORDS);

localparam logic [5:0] alu_fns [8] = '{
	fn_addu, fn_subu, fn_and, fn_or, fn_xor, fn_slt, fn_sll, fn_srl
};
localparam logic [5:0] imm_ops [4] = '{op_addiu, op_andi, op_ori, op_lui};

// Architectural state of the model.
logic [31:0] mrf [32];
logic [31:0] mdm [DMEM_WORDS];
int          pending_tag;

// Random operands stay in r0..r7, which the prologue defines.
function automatic logic [4:0] pick_reg();
	return 5'($urandom % 8);
endfunction

function automatic logic [31:0] enc_r(input logic [4:0] rs, input logic [4:0] rt,
		input logic [4:0] rd, input logic [4:0] sh, input logic [5:0] fn);
	return {op_rtype, rs, rt, rd, sh, fn};
endfunction

function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
	return {op, rs, rt, imm};
endfunction

// The first result after a flow change is credited to that branch or jump.
function automatic int take_tag(input int tag);
	int t;
	t = (pending_tag >= 0) ? pending_tag : tag;
	pending_tag = -1;
	return t;
endfunction

// Every instruction is followed by two nops (sll r0,r0,0).
task automatic emit(input logic [31:0] inst);
	prog[prog_len] = inst;
	prog[prog_len + 1] = 32'd0;
	prog[prog_len + 2] = 32'd0;
	prog_len += 3;
endtask

task automatic build_program();
	int          kind [n_groups];
	int          start [n_groups + 1];
	int          tg;
	logic [31:0] tw;
	logic [5:0]  op;
	logic [4:0]  rs;
	logic [4:0]  rt;
	prog_len = 0;
	// Prologue seeds r1..r7 and then every data word.
	for (int r = 1; r < 8; r++)
		emit(enc_i(op_addiu, 5'd0, 5'(r), 16'($urandom)));
	for (int w = 0; w < DMEM_WORDS; w++)
		emit(enc_i(op_sw, 5'd0, 5'(w % 7 + 1), 16'(w * 4)));
	// Lay out the groups first so that forward targets are known.
	// Kinds 8 and 9 (jr, jalr) set r7 to their target in an extra slot.
	start[0] = prog_len;
	for (int g = 0; g < n_groups; g++) begin
		kind[g] = int'($urandom % n_kinds);
		start[g + 1] = start[g] + ((kind[g] >= 8) ? 6 : 3);
	end
	end_addr = 32'(start[n_groups] * 4);
	for (int g = 0; g < n_groups; g++) begin
		tg = g + 1 + int'($urandom % 3);
		if (tg > n_groups)
			tg = n_groups;
		tw = 32'(start[tg]);
		case (kind[g])
			0: emit(enc_r(pick_reg(), pick_reg(), pick_reg(), 5'($urandom),
				alu_fns[3'($urandom)]));
			1: begin
				op = imm_ops[2'($urandom)];
				rs = (op == op_lui) ? 5'd0 : pick_reg();
				emit(enc_i(op, rs, pick_reg(), 16'($urandom)));
			end
			2: emit(enc_i(op_sw, 5'd0, pick_reg(), 16'(($urandom % DMEM_WORDS) * 4)));
			3: emit(enc_i(op_lw, 5'd0, pick_reg(), 16'(($urandom % DMEM_WORDS) * 4)));
			4, 5: begin
				rs = pick_reg();
				rt = ($urandom % 2 == 0) ? rs : pick_reg();
				op = (kind[g] == 4) ? op_beq : op_bne;
				emit(enc_i(op, rs, rt, 16'(tw - 32'(prog_len) - 32'd1)));
			end
			6: emit({op_j, tw[25:0]});
			7: emit({op_jal, tw[25:0]});
			default: begin
				emit(enc_i(op_addiu, 5'd0, 5'd7, 16'(tw * 4)));
				if (kind[g] == 8)
					emit(enc_r(5'd7, 5'd0, 5'd0, 5'd0, fn_jr));
				else
					emit(enc_r(5'd7, 5'd0, pick_reg(), 5'd0, fn_jalr));
			end
		endcase
	end
	// Final self-loop.
	emit({op_j, end_addr[27:2]});
endtask

task automatic record_wb(input logic [4:0] dst, input logic [31:0] val, input int tag);
	wb_t e;
	e.rfw = 1'b1;
	e.waddr = dst;
	e.wdata = val;
	exp_wb.push_back(e);
	exp_wb_tag.push_back(take_tag(tag));
	if (dst != 5'd0)
		mrf[dst] = val;
endtask

// Executes the program one instruction at a time until the self-loop.
task automatic run_model();
	logic [31:0] pc;
	logic [31:0] pc4;
	logic [31:0] nxt;
	logic [31:0] inst;
	logic [31:0] a;
	logic [31:0] b;
	logic [31:0] simm;
	logic [31:0] zimm;
	logic [31:0] ea;
	logic [4:0]  rt;
	logic [4:0]  rd;
	st_t         s;
	for (int i = 0; i < 32; i++)
		mrf[i] = 32'd0;
	pc = 32'd0;
	pending_tag = -1;
	while (pc != end_addr) begin
		inst = prog[pc[iaw+1:2]];
		a = mrf[inst[25:21]];
		b = mrf[inst[20:16]];
		rt = inst[20:16];
		rd = inst[15:11];
		simm = {{16{inst[15]}}, inst[15:0]};
		zimm = {16'd0, inst[15:0]};
		ea = a + simm;
		pc4 = pc + 32'd4;
		nxt = pc4;
		case (inst[31:26])
			op_rtype: begin
				case (inst[5:0])
					fn_addu: record_wb(rd, a + b, t_alu);
					fn_subu: record_wb(rd, a - b, t_alu);
					fn_and:  record_wb(rd, a & b, t_alu);
					fn_or:   record_wb(rd, a | b, t_alu);
					fn_xor:  record_wb(rd, a ^ b, t_alu);
					fn_slt:  record_wb(rd, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0, t_alu);
					fn_sll:  record_wb(rd, b << inst[10:6], t_alu);
					fn_srl:  record_wb(rd, b >> inst[10:6], t_alu);
					fn_jr: begin
						nxt = a;
						pending_tag = t_jump;
					end
					fn_jalr: begin
						record_wb(rd, pc4, t_jump);
						nxt = a;
					end
					default: ;
				endcase
			end
			op_addiu: record_wb(rt, a + simm, t_imm);
			op_andi:  record_wb(rt, a & zimm, t_imm);
			op_ori:   record_wb(rt, a | zimm, t_imm);
			op_lui:   record_wb(rt, {inst[15:0], 16'd0}, t_imm);
			op_lw:    record_wb(rt, mdm[ea[daw+1:2]], t_mem);
			op_sw: begin
				mdm[ea[daw+1:2]] = b;
				s.addr = ea;
				s.data = b;
				exp_st.push_back(s);
				exp_st_tag.push_back(take_tag(t_mem));
			end
			op_beq, op_bne: begin
				if ((a == b) == (inst[31:26] == op_beq))
					nxt = pc4 + {simm[29:0], 2'b00};
				pending_tag = t_branch;
			end
			op_j, op_jal: begin
				nxt = {pc4[31:28], inst[25:0], 2'b00};
				if (inst[31:26] == op_jal)
					record_wb(5'd31, pc4, t_jump);
				else
					pending_tag = t_jump;
			end
			default: ;
		endcase
		pc = nxt;
	end
endtask

`endif

// File: sim/tb_cpu.sv
// Testbench top: loads a random MIPS program, runs the pipeline and checks retires and stores.
`default_nettype none
`timescale 1ns/100ps

module tb_cpu;

	import cpu_pkg::*;

	localparam int IMEM_WORDS      = 1024;
	localparam int DMEM_WORDS      = 16;
	localparam int clk_period      = 8;
	localparam int reset_cycles    = 10;
	localparam int cycles_per_word = 20;
	localparam int n_tests         = 6;

	logic        clk;
	logic        rst;
	logic        prog_we;
	logic [31:0] prog_addr;
	logic [31:0] prog_data;
	wb_t         wb;
	logic        st_valid;
	st_t         st;

	// Program image and the results that the model expects, in order.
	logic [31:0] prog [IMEM_WORDS];
	int          prog_len;
	logic [31:0] end_addr;
	logic        prog_built;
	wb_t         exp_wb [$];
	int          exp_wb_tag [$];
	st_t         exp_st [$];
	int          exp_st_tag [$];

	int          checks [n_tests];
	int          errors [n_tests];
	int          stray_errors;
	string       test_name [n_tests];

	`include "tb_isa_model.svh"

	tb_clk #(
		.PERIOD_NS(clk_period)
	) clk0 (
		.clk(clk)
	);

	cpu_top #(
		.IMEM_WORDS(IMEM_WORDS),
		.DMEM_WORDS(DMEM_WORDS)
	) dut0 (
		.clk      (clk),
		.rst      (rst),
		.prog_we  (prog_we),
		.prog_addr(prog_addr),
		.prog_data(prog_data),
		.wb       (wb),
		.st_valid (st_valid),
		.st       (st)
	);

	// ----------------------------------------------------------------------
	// Compare tasks.
	// ----------------------------------------------------------------------
	task automatic check_wb(input wb_t act);
		wb_t exp;
		int  tag;
		if (exp_wb.size() == 0) begin
			stray_errors++;
			$display("Register write r%0d=%h arrived with none left in the model",
				act.waddr, act.wdata);
		end else begin
			exp = exp_wb.pop_front();
			tag = exp_wb_tag.pop_front();
			checks[tag]++;
			if (act !== exp) begin
				errors[tag]++;
				$display("FAIL %s: expected rfw=%0b r%0d=%h, actual rfw=%0b r%0d=%h",
					test_name[tag], exp.rfw, exp.waddr, exp.wdata,
					act.rfw, act.waddr, act.wdata);
			end
		end
	endtask

	task automatic check_st(input st_t act);
		st_t exp;
		int  tag;
		if (exp_st.size() == 0) begin
			stray_errors++;
			$display("Store to %h arrived with none left in the model", act.addr);
		end else begin
			exp = exp_st.pop_front();
			tag = exp_st_tag.pop_front();
			checks[tag]++;
			if (act !== exp) begin
				errors[tag]++;
				$display("FAIL %s: expected store [%h]=%h, actual store [%h]=%h",
					test_name[tag], exp.addr, exp.data, act.addr, act.data);
			end
		end
	endtask

	// Outputs are registered on the rising edge, so sample them on the falling one.
	always @(negedge clk) begin
		if (rst === 1'b1) begin
			checks[t_reset]++;
			if (wb.rfw !== 1'b0 || st_valid !== 1'b0) begin
				errors[t_reset]++;
				$display("Retire or store strobe was not low during reset");
			end
		end else if (prog_built === 1'b1) begin
			if (wb.rfw !== 1'b0)
				check_wb(wb);
			if (st_valid !== 1'b0)
				check_st(st);
		end
	end

	// Watchdog, scaled to the program length.
	initial begin
		wait (prog_built === 1'b1);
		#(prog_len * cycles_per_word * clk_period);
		$display("Watchdog expired before the program reached its final loop");
		$display("TB FAILED");
		$finish;
	end

	// ----------------------------------------------------------------------
	// Main sequence.
	// ----------------------------------------------------------------------
	initial begin
		int drive_cycles;
		int total_checks;
		int total_errors;
		rst = 1'b1;
		prog_we = 1'b0;
		prog_addr = 32'd0;
		prog_data = 32'd0;
		prog_built = 1'b0;
		test_name = '{"reset", "alu", "imm", "mem", "branch", "jump"};
		void'($urandom(32'h2b52_8e48));
		build_program();
		run_model();
		prog_built = 1'b1;

		// Reset stays high for at least 10 cycles and until the load is done.
		drive_cycles = (prog_len > reset_cycles) ? prog_len : reset_cycles;
		for (int i = 0; i < drive_cycles; i++) begin
			@(posedge clk);
			prog_we <= (i < prog_len);
			prog_addr <= 32'(i * 4);
			prog_data <= (i < prog_len) ? prog[i] : 32'd0;
		end
		@(posedge clk);
		prog_we <= 1'b0;
		rst <= 1'b0;
		$display("test %s: %0d checks, %0d errors",
			test_name[t_reset], checks[t_reset], errors[t_reset]);

		// Wait for the self-loop to reach execute, then let older ones retire.
		@(negedge clk);
		while (!(dut0.id_ex.valid === 1'b1 && dut0.id_ex.pc === end_addr))
			@(negedge clk);
		repeat (3) @(negedge clk);

		for (int t = 1; t < n_tests; t++)
			$display("test %s: %0d checks, %0d errors", test_name[t], checks[t], errors[t]);
		if (exp_wb.size() != 0 || exp_st.size() != 0) begin
			stray_errors++;
			$display("Final loop reached with %0d register writes and %0d stores missing",
				exp_wb.size(), exp_st.size());
		end
		total_checks = 0;
		total_errors = stray_errors;
		for (int t = 0; t < n_tests; t++) begin
			total_checks += checks[t];
			total_errors += errors[t];
		end
		$display("total: %0d checks, %0d errors", total_checks, total_errors);
		if (total_errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: src.f
+incdir+sim
verilog/cpu_pkg.sv
verilog/cpu_if.sv
verilog/cpu_id.sv
verilog/cpu_ex.sv
verilog/cpu_mem.sv
verilog/cpu_top.sv
sim/tb_clk.sv
sim/tb_cpu.sv

// File: Makefile
# Verilator build for the MIPS pipeline testbench.

VERILATOR ?= verilator
TOP       ?= tb_cpu
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)

SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST) sim/tb_isa_model.svh
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TB FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TB PASSED" $(LOG) || { echo "simulation ended without a result"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
